// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_periph_top
FILELIST  = all.f
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+tb
verilog/periph_pkg.sv
verilog/axi4l_to_wishbone.sv
verilog/wb_page_decode.sv
verilog/mul_accel.sv
verilog/led_ctrl.sv
verilog/periph_top.sv
tb/tb_periph_top.sv

// ==== tb/tb_axi4l_master.svh ====
`ifndef TB_AXI4L_MASTER_SVH
`define TB_AXI4L_MASTER_SVH

// Single write with address and data offered together
task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr,
                         input logic [DATA_WIDTH-1:0]     data,
                         input logic [SEL_WIDTH-1:0]      strb);
    int unsigned stall;
    int unsigned latency;
    stall     = $urandom_range(3, 0);
    latency   = 0;
    awaddr_i  <= addr;
    wdata_i   <= data;
    wstrb_i   <= strb;
    awvalid_i <= 1'b1;
    wvalid_i  <= 1'b1;
    @(posedge clk);
    while (!(awready_o && wready_o)) begin
        @(posedge clk);
    end
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    while (!bvalid_o) begin
        @(posedge clk);
        latency++;
        // Ready is a single-cycle pulse
        check("awready_o", 64'(awready_o), 64'd0);
        check("wready_o", 64'(wready_o), 64'd0);
    end
    check("write latency", 64'(latency), 64'd2);
    check("bresp_o", 64'(bresp_o), 64'(RESP_OKAY));
    // Response holds under back-pressure
    repeat (stall) begin
        @(posedge clk);
        check("bvalid_o", 64'(bvalid_o), 64'd1);
        check("bresp_o", 64'(bresp_o), 64'(RESP_OKAY));
    end
    bready_i <= 1'b1;
    @(posedge clk);
    bready_i <= 1'b0;
    @(posedge clk);
    // One response per write
    check("bvalid_o", 64'(bvalid_o), 64'd0);
endtask

// Single read with data taken at the first valid cycle
task automatic axi_read(input  logic [AXI_ADDR_WIDTH-1:0] addr,
                        output logic [DATA_WIDTH-1:0]     data);
    int unsigned           stall;
    int unsigned           latency;
    logic [DATA_WIDTH-1:0] held;
    stall     = $urandom_range(3, 0);
    latency   = 0;
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    @(posedge clk);
    while (!arready_o) begin
        @(posedge clk);
    end
    arvalid_i <= 1'b0;
    while (!rvalid_o) begin
        @(posedge clk);
        latency++;
        check("arready_o", 64'(arready_o), 64'd0);
    end
    check("read latency", 64'(latency), 64'd2);
    check("rresp_o", 64'(rresp_o), 64'(RESP_OKAY));
    held = rdata_o;
    repeat (stall) begin
        @(posedge clk);
        check("rvalid_o", 64'(rvalid_o), 64'd1);
        check("rdata_o", rdata_o, held);
    end
    rready_i <= 1'b1;
    @(posedge clk);
    rready_i <= 1'b0;
    @(posedge clk);
    check("rvalid_o", 64'(rvalid_o), 64'd0);
    data = held;
endtask

`endif

// ==== tb/tb_periph_top.sv ====
`default_nettype none

module tb_periph_top;
    import periph_pkg::*;

    localparam int COUNT_WIDTH = 4;
    localparam logic [31:0] SEED = 32'h5072;

    localparam int N_LED      = 30;
    localparam int N_PROD     = 40;
    localparam int N_STRB     = 10;
    localparam int N_UNMAP    = 10;
    localparam int POLL_LIMIT = 40;

    // Worst case with every product polling up to the limit
    localparam int N_TXN = 2 * N_LED + N_PROD * (5 + POLL_LIMIT) + 2 * N_STRB
                           + 2 * N_UNMAP + 3;
    localparam int WATCHDOG_CYCLES = 200 * N_TXN;

    logic                      clk;
    logic                      resetn;
    logic [AXI_ADDR_WIDTH-1:0] awaddr_i;
    logic                      awvalid_i;
    logic                      awready_o;
    logic [DATA_WIDTH-1:0]     wdata_i;
    logic [SEL_WIDTH-1:0]      wstrb_i;
    logic                      wvalid_i;
    logic                      wready_o;
    logic [1:0]                bresp_o;
    logic                      bvalid_o;
    logic                      bready_i;
    logic [AXI_ADDR_WIDTH-1:0] araddr_i;
    logic                      arvalid_i;
    logic                      arready_o;
    logic [DATA_WIDTH-1:0]     rdata_o;
    logic [1:0]                rresp_o;
    logic                      rvalid_o;
    logic                      rready_i;
    logic [1:0]                led_o;

    // Reference model state
    logic                      led_model;
    logic [31:0]               op_a_model;
    logic [31:0]               op_b_model;

    periph_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .led_o     (led_o)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Failure handling and checks
    // ----------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    `include "tb_axi4l_master.svh"

    // Byte address of a word in a page at 8 bytes per word
    function automatic logic [AXI_ADDR_WIDTH-1:0] word_addr(input logic [7:0] page,
                                                            input logic [7:0] ofs);
        return {21'b0, page, ofs, 3'b000};
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // Operand bytes take new data only where the strobe is set
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // ----------------------------------------
    // Watchdog and blink counter
    // ----------------------------------------

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                            WATCHDOG_CYCLES));
    end

    // Counter is zero after the release edge and its top bit flips every 8 cycles
    initial begin : blink_check
        int unsigned cycles;
        cycles = 0;
        @(posedge resetn);
        forever begin
            @(negedge clk);
            check("led_o[1]", 64'(led_o[1]), 64'((cycles / 8) % 2));
            @(posedge clk);
            cycles++;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : main
        logic [63:0] rdata;
        logic [63:0] wdata;
        logic [7:0]  strb;
        logic [7:0]  ofs;
        logic [7:0]  page;
        logic [31:0] a;
        logic [31:0] b;
        logic        use_b;
        int unsigned polls;

        void'($urandom(SEED));
        clk       = 1'b0;
        resetn    = 1'b0;
        awaddr_i  = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        wvalid_i  = 1'b0;
        bready_i  = 1'b0;
        araddr_i  = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b0;
        led_model  = 1'b0;
        op_a_model = '0;
        op_b_model = '0;

        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        // LED register under random strobes
        for (int i = 0; i < N_LED; i++) begin
            wdata = rand64();
            strb  = 8'($urandom);
            axi_write(word_addr(PAGE_LED, REG_LED), wdata, strb);
            if (strb[0]) begin
                led_model = wdata[0];
            end
            axi_read(word_addr(PAGE_LED, REG_LED), rdata);
            check("led register", rdata, 64'(led_model));
            check("led_o[0]", 64'(led_o[0]), 64'(led_model));
        end

        // Products with the largest operands as the first pair
        for (int i = 0; i < N_PROD; i++) begin
            a = (i == 0) ? 32'hffff_ffff : $urandom;
            b = (i == 0) ? 32'hffff_ffff : $urandom;
            axi_write(word_addr(PAGE_ACCEL, REG_OP_A), {$urandom, a}, 8'hff);
            axi_write(word_addr(PAGE_ACCEL, REG_OP_B), {$urandom, b}, 8'hff);
            op_a_model = a;
            op_b_model = b;
            axi_write(word_addr(PAGE_ACCEL, REG_CTRL), 64'h1, 8'h01);
            axi_read(word_addr(PAGE_ACCEL, REG_CTRL), rdata);
            check("ctrl after start", rdata, 64'h1);
            polls = 0;
            while (!rdata[1]) begin
                if (polls == POLL_LIMIT) begin
                    abort_run("Accelerator never reported done while polling");
                end
                axi_read(word_addr(PAGE_ACCEL, REG_CTRL), rdata);
                polls++;
            end
            check("ctrl when done", rdata, 64'h2);
            axi_read(word_addr(PAGE_ACCEL, REG_RESULT), rdata);
            check("result", rdata, 64'(a) * 64'(b));
        end

        // Partial strobes merge into the operands
        for (int i = 0; i < N_STRB; i++) begin
            use_b = 1'($urandom);
            ofs   = use_b ? REG_OP_B : REG_OP_A;
            wdata = rand64();
            strb  = 8'($urandom);
            axi_write(word_addr(PAGE_ACCEL, ofs), wdata, strb);
            if (use_b) begin
                op_b_model = merge_bytes(op_b_model, wdata[31:0], strb[3:0]);
            end else begin
                op_a_model = merge_bytes(op_a_model, wdata[31:0], strb[3:0]);
            end
            axi_read(word_addr(PAGE_ACCEL, ofs), rdata);
            check(use_b ? "op_b" : "op_a", rdata, 64'(use_b ? op_b_model : op_a_model));
        end

        // Unmapped pages
        for (int i = 0; i < N_UNMAP; i++) begin
            page = 8'($urandom);
            while (page == PAGE_ACCEL || page == PAGE_LED) begin
                page = 8'($urandom);
            end
            axi_read({21'($urandom), page, 8'($urandom), 3'b000}, rdata);
            check("unmapped rdata", rdata, 64'h0);
            axi_write({21'($urandom), page, 8'($urandom), 3'b000}, rand64(), 8'hff);
        end
        axi_read(word_addr(PAGE_LED, REG_LED), rdata);
        check("led after unmapped", rdata, 64'(led_model));
        axi_read(word_addr(PAGE_ACCEL, REG_OP_A), rdata);
        check("op_a after unmapped", rdata, 64'(op_a_model));
        axi_read(word_addr(PAGE_ACCEL, REG_OP_B), rdata);
        check("op_b after unmapped", rdata, 64'(op_b_model));

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/axi4l_to_wishbone.sv ====
`default_nettype none

module axi4l_to_wishbone (
    input  logic                                  clk,
    input  logic                                  resetn,

    input  logic [periph_pkg::AXI_ADDR_WIDTH-1:0] awaddr_i,
    input  logic                                  awvalid_i,
    output logic                                  awready_o,
    input  logic [periph_pkg::DATA_WIDTH-1:0]     wdata_i,
    input  logic [periph_pkg::SEL_WIDTH-1:0]      wstrb_i,
    input  logic                                  wvalid_i,
    output logic                                  wready_o,
    output logic [1:0]                            bresp_o,
    output logic                                  bvalid_o,
    input  logic                                  bready_i,

    input  logic [periph_pkg::AXI_ADDR_WIDTH-1:0] araddr_i,
    input  logic                                  arvalid_i,
    output logic                                  arready_o,
    output logic [periph_pkg::DATA_WIDTH-1:0]     rdata_o,
    output logic [1:0]                            rresp_o,
    output logic                                  rvalid_o,
    input  logic                                  rready_i,

    output periph_pkg::wb_req_t                   wb_req_o,
    input  periph_pkg::wb_rsp_t                   wb_rsp_i
);
    import periph_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_CYC,
        ST_RD_CYC,
        ST_WR_RSP,
        ST_RD_RSP
    } state_t;

    state_t                  state;
    logic                    aw_accept;
    logic                    ar_accept;
    logic                    stb;

    // Latched request payload
    wb_adr_u                 adr_q;
    logic [DATA_WIDTH-1:0]   dat_q;
    logic [SEL_WIDTH-1:0]    sel_q;
    logic                    we_q;

    // Ready pulses only occur in idle, so valid here means a handshake
    assign aw_accept = awready_o && awvalid_i && wvalid_i;
    assign ar_accept = arready_o && arvalid_i;

    assign stb = (state == ST_WR_CYC) || (state == ST_RD_CYC);

    // --------------------------------------
    // Control FSM
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            arready_o <= 1'b0;
            bvalid_o  <= 1'b0;
            rvalid_o  <= 1'b0;
        end else begin
            // Single-cycle ready pulses
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            arready_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (aw_accept) begin
                        state <= ST_WR_CYC;
                    end else if (ar_accept) begin
                        state <= ST_RD_CYC;
                    end else if (awvalid_i && wvalid_i) begin
                        // Write wins over a pending read
                        awready_o <= 1'b1;
                        wready_o  <= 1'b1;
                    end else if (arvalid_i) begin
                        arready_o <= 1'b1;
                    end
                end
                ST_WR_CYC: begin
                    if (wb_rsp_i.ack) begin
                        bvalid_o <= 1'b1;
                        state    <= ST_WR_RSP;
                    end
                end
                ST_RD_CYC: begin
                    if (wb_rsp_i.ack) begin
                        rvalid_o <= 1'b1;
                        state    <= ST_RD_RSP;
                    end
                end
                ST_WR_RSP: begin
                    if (bready_i) begin
                        bvalid_o <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                ST_RD_RSP: begin
                    if (rready_i) begin
                        rvalid_o <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------
    // Request and read data capture
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && aw_accept) begin
            // Byte offset bits are dropped
            adr_q.raw <= awaddr_i[AXI_ADDR_WIDTH-1:DATA_SIZE];
            dat_q     <= wdata_i;
            sel_q     <= wstrb_i;
            we_q      <= 1'b1;
        end else if (state == ST_IDLE && ar_accept) begin
            adr_q.raw <= araddr_i[AXI_ADDR_WIDTH-1:DATA_SIZE];
            dat_q     <= '0;
            sel_q     <= '1;
            we_q      <= 1'b0;
        end
        if (state == ST_RD_CYC && wb_rsp_i.ack) begin
            rdata_o <= wb_rsp_i.dat;
        end
    end

    always_comb begin
        wb_req_o.adr = adr_q;
        wb_req_o.dat = dat_q;
        wb_req_o.we  = we_q;
        wb_req_o.sel = sel_q;
        wb_req_o.stb = stb;
    end

    assign bresp_o = RESP_OKAY;
    assign rresp_o = RESP_OKAY;

    // --------------------------------------
    // Protocol checks
    // --------------------------------------

    // Slave sees a steady request until it acks
    a_req_stable: assert property (@(posedge clk) disable iff (!resetn)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> $stable(wb_req_o));

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        (bvalid_o && !bready_i) |=> bvalid_o);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
        (rvalid_o && !rready_i) |=> rvalid_o);

endmodule

`default_nettype wire

// ==== verilog/led_ctrl.sv ====
`default_nettype none

module led_ctrl #(
    parameter int COUNT_WIDTH = 26
) (
    input  logic                clk,
    input  logic                resetn,
    input  periph_pkg::wb_req_t wb_req_i,
    output periph_pkg::wb_rsp_t wb_rsp_o,
    output logic [1:0]          led_o
);
    import periph_pkg::*;

    logic                    hit_led;
    logic                    led_q;
    logic [COUNT_WIDTH-1:0]  count_q;

    assign hit_led = (wb_req_i.adr.fields.reg_ofs == REG_LED);

    // --------------------------------------
    // LED register
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            led_q <= 1'b0;
        end else if (wb_req_i.stb && wb_req_i.we && wb_req_i.sel[0] && hit_led) begin
            led_q <= wb_req_i.dat[0];
        end
    end

    assign wb_rsp_o.dat = hit_led ? DATA_WIDTH'(led_q) : '0;
    assign wb_rsp_o.ack = wb_req_i.stb;

    // --------------------------------------
    // Blink counter
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // Top bit toggles every 2^(COUNT_WIDTH-1) cycles
    assign led_o = {count_q[COUNT_WIDTH-1], led_q};

endmodule

`default_nettype wire

// ==== verilog/mul_accel.sv ====
`default_nettype none

module mul_accel (
    input  logic                clk,
    input  logic                resetn,
    input  periph_pkg::wb_req_t wb_req_i,
    output periph_pkg::wb_rsp_t wb_rsp_o
);
    import periph_pkg::*;

    localparam int OP_WIDTH  = 32;
    localparam int CNT_WIDTH = $clog2(OP_WIDTH) + 1;

    logic [7:0]              reg_ofs;
    logic                    wr_en;
    logic                    start;

    logic [OP_WIDTH-1:0]     op_a_q;
    logic [OP_WIDTH-1:0]     op_b_q;
    logic [2*OP_WIDTH-1:0]   result_q;
    logic                    busy_q;
    logic                    done_q;
    logic [CNT_WIDTH-1:0]    step_q;

    // Shift registers of the multiplier
    logic [2*OP_WIDTH-1:0]   mcand_q;
    logic [OP_WIDTH-1:0]     mplier_q;

    assign reg_ofs = wb_req_i.adr.fields.reg_ofs;
    assign wr_en   = wb_req_i.stb && wb_req_i.we;

    // Start is ignored while a run is in progress
    assign start = wr_en && (reg_ofs == REG_CTRL) && wb_req_i.sel[0]
                   && wb_req_i.dat[0] && !busy_q;

    // --------------------------------------
    // Operand registers
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            op_a_q <= '0;
            op_b_q <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < OP_WIDTH / 8; i++) begin
                if (wb_req_i.sel[i] && reg_ofs == REG_OP_A) begin
                    op_a_q[8*i +: 8] <= wb_req_i.dat[8*i +: 8];
                end
                if (wb_req_i.sel[i] && reg_ofs == REG_OP_B) begin
                    op_b_q[8*i +: 8] <= wb_req_i.dat[8*i +: 8];
                end
            end
        end
    end

    // --------------------------------------
    // Shift-add multiplier
    // --------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            step_q   <= '0;
            result_q <= '0;
        end else if (start) begin
            busy_q   <= 1'b1;
            done_q   <= 1'b0;
            step_q   <= '0;
            result_q <= '0;
        end else if (busy_q) begin
            // Result doubles as the accumulator
            if (mplier_q[0]) begin
                result_q <= result_q + mcand_q;
            end
            step_q <= step_q + 1'b1;
            if (step_q == CNT_WIDTH'(OP_WIDTH - 1)) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand_q  <= {{OP_WIDTH{1'b0}}, op_a_q};
            mplier_q <= op_b_q;
        end else if (busy_q) begin
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // --------------------------------------
    // Read mux
    // --------------------------------------

    always_comb begin
        wb_rsp_o.ack = wb_req_i.stb;
        case (reg_ofs)
            REG_CTRL:   wb_rsp_o.dat = DATA_WIDTH'({done_q, busy_q});
            REG_OP_A:   wb_rsp_o.dat = DATA_WIDTH'(op_a_q);
            REG_OP_B:   wb_rsp_o.dat = DATA_WIDTH'(op_b_q);
            REG_RESULT: wb_rsp_o.dat = result_q;
            default:    wb_rsp_o.dat = '0;
        endcase
    end

    a_step_range: assert property (@(posedge clk) disable iff (!resetn)
        step_q <= CNT_WIDTH'(OP_WIDTH));

endmodule

`default_nettype wire

// ==== verilog/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // --------------------------------------
    // Bus widths
    // --------------------------------------

    localparam int AXI_ADDR_WIDTH = 40;
    // log2 of bytes per word
    localparam int DATA_SIZE      = 3;
    localparam int DATA_WIDTH     = 8 << DATA_SIZE;
    localparam int SEL_WIDTH      = 1 << DATA_SIZE;
    localparam int WB_ADR_WIDTH   = AXI_ADDR_WIDTH - DATA_SIZE;

    // Every response is OKAY
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // --------------------------------------
    // Wishbone word address
    // --------------------------------------

    // Page and register view used by the decoder and slaves
    typedef struct packed {
        logic [WB_ADR_WIDTH-17:0] upper;
        logic [7:0]               page;
        logic [7:0]               reg_ofs;
    } wb_adr_fields_t;

    // Raw word index from the bridge, or the split fields
    typedef union packed {
        logic [WB_ADR_WIDTH-1:0] raw;
        wb_adr_fields_t          fields;
    } wb_adr_u;

    // --------------------------------------
    // Wishbone request and response
    // --------------------------------------

    typedef struct packed {
        wb_adr_u                 adr;
        logic [DATA_WIDTH-1:0]   dat;
        logic                    we;
        logic [SEL_WIDTH-1:0]    sel;
        logic                    stb;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]   dat;
        logic                    ack;
    } wb_rsp_t;

    // --------------------------------------
    // Register map
    // --------------------------------------

    localparam logic [7:0] PAGE_ACCEL = 8'h00;
    localparam logic [7:0] PAGE_LED   = 8'h10;

    // Accelerator word offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_OP_A   = 8'h01;
    localparam logic [7:0] REG_OP_B   = 8'h02;
    localparam logic [7:0] REG_RESULT = 8'h03;

    // LED block word offset
    localparam logic [7:0] REG_LED    = 8'h00;

endpackage

`default_nettype wire

// ==== verilog/periph_top.sv ====
`default_nettype none

module periph_top #(
    parameter int COUNT_WIDTH = 26
) (
    input  logic                                  clk,
    input  logic                                  resetn,

    input  logic [periph_pkg::AXI_ADDR_WIDTH-1:0] awaddr_i,
    input  logic                                  awvalid_i,
    output logic                                  awready_o,
    input  logic [periph_pkg::DATA_WIDTH-1:0]     wdata_i,
    input  logic [periph_pkg::SEL_WIDTH-1:0]      wstrb_i,
    input  logic                                  wvalid_i,
    output logic                                  wready_o,
    output logic [1:0]                            bresp_o,
    output logic                                  bvalid_o,
    input  logic                                  bready_i,

    input  logic [periph_pkg::AXI_ADDR_WIDTH-1:0] araddr_i,
    input  logic                                  arvalid_i,
    output logic                                  arready_o,
    output logic [periph_pkg::DATA_WIDTH-1:0]     rdata_o,
    output logic [1:0]                            rresp_o,
    output logic                                  rvalid_o,
    input  logic                                  rready_i,

    output logic [1:0]                            led_o
);
    import periph_pkg::*;

    // Shared bus from the bridge
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    // Per-slave legs
    wb_req_t accel_req;
    wb_rsp_t accel_rsp;
    wb_req_t led_req;
    wb_rsp_t led_rsp;

    // --------------------------------------
    // AXI4-Lite to Wishbone bridge
    // --------------------------------------

    axi4l_to_wishbone u_bridge (
        .clk       (clk),
        .resetn    (resetn),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .araddr_i  (araddr_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .wb_req_o  (bus_req),
        .wb_rsp_i  (bus_rsp)
    );

    // --------------------------------------
    // Page decode and slaves
    // --------------------------------------

    wb_page_decode u_decode (
        .wb_req_i    (bus_req),
        .wb_rsp_o    (bus_rsp),
        .accel_req_o (accel_req),
        .accel_rsp_i (accel_rsp),
        .led_req_o   (led_req),
        .led_rsp_i   (led_rsp)
    );

    mul_accel u_accel (
        .clk      (clk),
        .resetn   (resetn),
        .wb_req_i (accel_req),
        .wb_rsp_o (accel_rsp)
    );

    led_ctrl #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_led (
        .clk      (clk),
        .resetn   (resetn),
        .wb_req_i (led_req),
        .wb_rsp_o (led_rsp),
        .led_o    (led_o)
    );

endmodule

`default_nettype wire

// ==== verilog/wb_page_decode.sv ====
`default_nettype none

module wb_page_decode (
    input  periph_pkg::wb_req_t wb_req_i,
    output periph_pkg::wb_rsp_t wb_rsp_o,

    output periph_pkg::wb_req_t accel_req_o,
    input  periph_pkg::wb_rsp_t accel_rsp_i,

    output periph_pkg::wb_req_t led_req_o,
    input  periph_pkg::wb_rsp_t led_rsp_i
);
    import periph_pkg::*;

    logic hit_accel;
    logic hit_led;

    assign hit_accel = (wb_req_i.adr.fields.page == PAGE_ACCEL);
    assign hit_led   = (wb_req_i.adr.fields.page == PAGE_LED);

    // --------------------------------------
    // Strobe gating
    // --------------------------------------

    always_comb begin
        accel_req_o     = wb_req_i;
        accel_req_o.stb = wb_req_i.stb && hit_accel;
        led_req_o       = wb_req_i;
        led_req_o.stb   = wb_req_i.stb && hit_led;
    end

    // --------------------------------------
    // Response select
    // --------------------------------------

    always_comb begin
        if (hit_accel) begin
            wb_rsp_o = accel_rsp_i;
        end else if (hit_led) begin
            wb_rsp_o = led_rsp_i;
        end else begin
            // Unmapped page acks with zero data
            wb_rsp_o.dat = '0;
            wb_rsp_o.ack = wb_req_i.stb;
        end
    end

endmodule

`default_nettype wire
